// ==== src/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    // Architectural register file
    localparam int NUM_REGS = 16;
    localparam int REG_IDX_W = 4;

    // Datapath and immediate widths
    localparam int DATA_W = 32;
    localparam int IMM_W = 16;

    // ROB and reservation stations share this depth
    localparam int ROB_DEPTH = 8;
    localparam int TAG_W = 3;

    // ALU opcodes
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_SLT  = 3'd5,
        // Sign-extended immediate added to rs1
        OP_ADDI = 3'd6,
        // Immediate into the upper half, lower half zero
        OP_LUI  = 3'd7
    } alu_op_e;

endpackage

`default_nettype wire

// ==== src/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            ex_valid,
    input  ooo_pkg::alu_op_e               ex_op,
    input  wire [ooo_pkg::DATA_W-1:0]      ex_a,
    input  wire [ooo_pkg::DATA_W-1:0]      ex_b,
    input  wire [ooo_pkg::TAG_W-1:0]       ex_tag,
    output logic                           cdb_valid,
    output logic [ooo_pkg::TAG_W-1:0]      cdb_tag,
    output logic [ooo_pkg::DATA_W-1:0]     cdb_data
);

    logic [ooo_pkg::DATA_W-1:0] result;

    always_comb begin
        case (ex_op)
            ooo_pkg::OP_ADD:  result = ex_a + ex_b;
            ooo_pkg::OP_SUB:  result = ex_a - ex_b;
            ooo_pkg::OP_AND:  result = ex_a & ex_b;
            ooo_pkg::OP_OR:   result = ex_a | ex_b;
            ooo_pkg::OP_XOR:  result = ex_a ^ ex_b;
            // Signed compare giving 1 or 0
            ooo_pkg::OP_SLT:  result = {{(ooo_pkg::DATA_W-1){1'b0}}, $signed(ex_a) < $signed(ex_b)};
            ooo_pkg::OP_ADDI: result = ex_a + ex_b;
            // Operand b already holds the shifted immediate
            ooo_pkg::OP_LUI:  result = ex_b;
            default:          result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            cdb_valid <= 1'b0;
        else
            cdb_valid <= ex_valid;
        cdb_tag <= ex_tag;
        cdb_data <= result;
    end

endmodule

`default_nettype wire

// ==== src/reservation_station.sv ====
`timescale 1ns/1ps
`default_nettype none

module reservation_station (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            issue_valid,
    input  ooo_pkg::alu_op_e               issue_op,
    input  wire [ooo_pkg::IMM_W-1:0]       issue_imm,
    input  wire [ooo_pkg::TAG_W-1:0]       alloc_tag,
    input  wire                            src1_ready,
    input  wire [ooo_pkg::TAG_W-1:0]       src1_tag,
    input  wire [ooo_pkg::DATA_W-1:0]      src1_val,
    input  wire                            src2_ready,
    input  wire [ooo_pkg::TAG_W-1:0]       src2_tag,
    input  wire [ooo_pkg::DATA_W-1:0]      src2_val,
    input  wire                            cdb_valid,
    input  wire [ooo_pkg::TAG_W-1:0]       cdb_tag,
    input  wire [ooo_pkg::DATA_W-1:0]      cdb_data,
    output logic                           ex_valid,
    output ooo_pkg::alu_op_e               ex_op,
    output logic [ooo_pkg::DATA_W-1:0]     ex_a,
    output logic [ooo_pkg::DATA_W-1:0]     ex_b,
    output logic [ooo_pkg::TAG_W-1:0]      ex_tag
);

    logic [ooo_pkg::ROB_DEPTH-1:0] ent_valid, rdy_a, rdy_b;
    ooo_pkg::alu_op_e              ent_op [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::TAG_W-1:0]     ent_tag [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::TAG_W-1:0]     wait_a [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::TAG_W-1:0]     wait_b [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::DATA_W-1:0]    val_a [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::DATA_W-1:0]    val_b [ooo_pkg::ROB_DEPTH];

    logic [ooo_pkg::TAG_W-1:0] free_idx, sel_idx;
    logic                      sel_found;

    // Immediate forms take operand b from the instruction
    logic                       use_imm;
    logic [ooo_pkg::DATA_W-1:0] imm_val;

    assign use_imm = issue_op == ooo_pkg::OP_ADDI || issue_op == ooo_pkg::OP_LUI;
    assign imm_val = (issue_op == ooo_pkg::OP_LUI)
                   ? {issue_imm, {(ooo_pkg::DATA_W-ooo_pkg::IMM_W){1'b0}}}
                   : {{(ooo_pkg::DATA_W-ooo_pkg::IMM_W){issue_imm[ooo_pkg::IMM_W-1]}}, issue_imm};

    // Lowest free slot and lowest ready slot
    always_comb begin
        free_idx = '0;
        sel_idx = '0;
        sel_found = 1'b0;
        for (int i = ooo_pkg::ROB_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i])
                free_idx = ooo_pkg::TAG_W'(i);
            if (ent_valid[i] && rdy_a[i] && rdy_b[i]) begin
                sel_idx = ooo_pkg::TAG_W'(i);
                sel_found = 1'b1;
            end
        end
    end

    assign ex_valid = sel_found;
    assign ex_op = ent_op[sel_idx];
    assign ex_a = val_a[sel_idx];
    assign ex_b = val_b[sel_idx];
    assign ex_tag = ent_tag[sel_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_valid <= '0;
        end else begin
            if (sel_found)
                ent_valid[sel_idx] <= 1'b0;
            if (issue_valid)
                ent_valid[free_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        // Wakeup on the CDB
        for (int i = 0; i < ooo_pkg::ROB_DEPTH; i++) begin
            if (cdb_valid && !rdy_a[i] && wait_a[i] == cdb_tag) begin
                rdy_a[i] <= 1'b1;
                val_a[i] <= cdb_data;
            end
            if (cdb_valid && !rdy_b[i] && wait_b[i] == cdb_tag) begin
                rdy_b[i] <= 1'b1;
                val_b[i] <= cdb_data;
            end
        end
        if (issue_valid) begin
            ent_op[free_idx] <= issue_op;
            ent_tag[free_idx] <= alloc_tag;
            // LUI ignores rs1 and never waits on it
            rdy_a[free_idx] <= src1_ready || issue_op == ooo_pkg::OP_LUI;
            wait_a[free_idx] <= src1_tag;
            val_a[free_idx] <= src1_val;
            rdy_b[free_idx] <= src2_ready || use_imm;
            wait_b[free_idx] <= src2_tag;
            val_b[free_idx] <= use_imm ? imm_val : src2_val;
        end
    end

endmodule

`default_nettype wire

// ==== src/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            issue_valid,
    input  wire [ooo_pkg::REG_IDX_W-1:0]   issue_rd,
    input  wire [ooo_pkg::TAG_W-1:0]       rob_rd_tag1,
    input  wire [ooo_pkg::TAG_W-1:0]       rob_rd_tag2,
    input  wire                            cdb_valid,
    input  wire [ooo_pkg::TAG_W-1:0]       cdb_tag,
    input  wire [ooo_pkg::DATA_W-1:0]      cdb_data,
    output logic [ooo_pkg::TAG_W-1:0]      alloc_tag,
    output logic                           rob_rd_done1,
    output logic [ooo_pkg::DATA_W-1:0]     rob_rd_data1,
    output logic                           rob_rd_done2,
    output logic [ooo_pkg::DATA_W-1:0]     rob_rd_data2,
    output logic                           issue_credit,
    output logic                           commit_valid,
    output logic [ooo_pkg::REG_IDX_W-1:0]  commit_rd,
    output logic [ooo_pkg::TAG_W-1:0]      commit_tag,
    output logic [ooo_pkg::DATA_W-1:0]     commit_data
);

    logic [ooo_pkg::ROB_DEPTH-1:0] ent_valid;
    logic [ooo_pkg::ROB_DEPTH-1:0] ent_done;
    logic [ooo_pkg::REG_IDX_W-1:0] ent_rd [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::DATA_W-1:0]    ent_data [ooo_pkg::ROB_DEPTH];

    // Depth is a power of two, so the pointers wrap on their own
    logic [ooo_pkg::TAG_W-1:0] head, tail;

    // Credits still owed to the sender
    logic [ooo_pkg::TAG_W:0] owed;
    logic [ooo_pkg::TAG_W:0] owed_sum;

    assign alloc_tag = tail;

    assign commit_valid = ent_valid[head] && ent_done[head];
    assign commit_rd = ent_rd[head];
    assign commit_tag = head;
    assign commit_data = ent_data[head];

    // Operand bypass for results not yet committed
    assign rob_rd_done1 = ent_valid[rob_rd_tag1] && ent_done[rob_rd_tag1];
    assign rob_rd_data1 = ent_data[rob_rd_tag1];
    assign rob_rd_done2 = ent_valid[rob_rd_tag2] && ent_done[rob_rd_tag2];
    assign rob_rd_data2 = ent_data[rob_rd_tag2];

    assign owed_sum = owed + {{ooo_pkg::TAG_W{1'b0}}, commit_valid};

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_valid <= '0;
            ent_done <= '0;
            head <= '0;
            tail <= '0;
            owed <= (ooo_pkg::TAG_W+1)'(ooo_pkg::ROB_DEPTH);
            issue_credit <= 1'b0;
        end else begin
            if (commit_valid) begin
                ent_valid[head] <= 1'b0;
                head <= head + 1'b1;
            end
            if (cdb_valid)
                ent_done[cdb_tag] <= 1'b1;
            if (issue_valid) begin
                ent_valid[tail] <= 1'b1;
                ent_done[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end
            // One pulse per cycle until nothing is owed
            if (owed_sum != '0) begin
                issue_credit <= 1'b1;
                owed <= owed_sum - 1'b1;
            end else begin
                issue_credit <= 1'b0;
                owed <= owed_sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cdb_valid)
            ent_data[cdb_tag] <= cdb_data;
        if (issue_valid)
            ent_rd[tail] <= issue_rd;
    end

endmodule

`default_nettype wire

// ==== src/reg_rename.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_rename (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            issue_valid,
    input  wire [ooo_pkg::REG_IDX_W-1:0]   issue_rd,
    input  wire [ooo_pkg::REG_IDX_W-1:0]   issue_rs1,
    input  wire [ooo_pkg::REG_IDX_W-1:0]   issue_rs2,
    input  wire [ooo_pkg::TAG_W-1:0]       alloc_tag,
    input  wire                            rob_rd_done1,
    input  wire [ooo_pkg::DATA_W-1:0]      rob_rd_data1,
    input  wire                            rob_rd_done2,
    input  wire [ooo_pkg::DATA_W-1:0]      rob_rd_data2,
    input  wire                            cdb_valid,
    input  wire [ooo_pkg::TAG_W-1:0]       cdb_tag,
    input  wire [ooo_pkg::DATA_W-1:0]      cdb_data,
    input  wire                            commit_valid,
    input  wire [ooo_pkg::REG_IDX_W-1:0]   commit_rd,
    input  wire [ooo_pkg::TAG_W-1:0]       commit_tag,
    input  wire [ooo_pkg::DATA_W-1:0]      commit_data,
    output logic [ooo_pkg::TAG_W-1:0]      rob_rd_tag1,
    output logic [ooo_pkg::TAG_W-1:0]      rob_rd_tag2,
    output logic                           src1_ready,
    output logic [ooo_pkg::TAG_W-1:0]      src1_tag,
    output logic [ooo_pkg::DATA_W-1:0]     src1_val,
    output logic                           src2_ready,
    output logic [ooo_pkg::TAG_W-1:0]      src2_tag,
    output logic [ooo_pkg::DATA_W-1:0]     src2_val
);

    logic [ooo_pkg::DATA_W-1:0] reg_data [ooo_pkg::NUM_REGS];
    logic [ooo_pkg::TAG_W-1:0]  reg_tag [ooo_pkg::NUM_REGS];
    logic [ooo_pkg::NUM_REGS-1:0] reg_busy;

    // Returns {ready, value} for one source operand
    function automatic logic [ooo_pkg::DATA_W:0] resolve(
        input logic [ooo_pkg::REG_IDX_W-1:0] idx,
        input logic                          busy,
        input logic [ooo_pkg::TAG_W-1:0]     tag,
        input logic [ooo_pkg::DATA_W-1:0]    value,
        input logic                          rob_done,
        input logic [ooo_pkg::DATA_W-1:0]    rob_data
    );
        if (idx == '0)
            return {1'b1, {ooo_pkg::DATA_W{1'b0}}};
        else if (!busy)
            return {1'b1, value};
        else if (rob_done)
            return {1'b1, rob_data};
        // Result broadcast in this very cycle
        else if (cdb_valid && cdb_tag == tag)
            return {1'b1, cdb_data};
        else
            return {1'b0, {ooo_pkg::DATA_W{1'b0}}};
    endfunction

    assign rob_rd_tag1 = reg_tag[issue_rs1];
    assign rob_rd_tag2 = reg_tag[issue_rs2];
    assign src1_tag = reg_tag[issue_rs1];
    assign src2_tag = reg_tag[issue_rs2];

    assign {src1_ready, src1_val} = resolve(issue_rs1, reg_busy[issue_rs1], reg_tag[issue_rs1],
                                            reg_data[issue_rs1], rob_rd_done1, rob_rd_data1);
    assign {src2_ready, src2_val} = resolve(issue_rs2, reg_busy[issue_rs2], reg_tag[issue_rs2],
                                            reg_data[issue_rs2], rob_rd_done2, rob_rd_data2);

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_busy <= '0;
            for (int i = 0; i < ooo_pkg::NUM_REGS; i++) begin
                reg_data[i] <= '0;
                reg_tag[i] <= '0;
            end
        end else begin
            if (commit_valid && commit_rd != '0) begin
                reg_data[commit_rd] <= commit_data;
                // A newer producer may already own this register
                if (reg_busy[commit_rd] && reg_tag[commit_rd] == commit_tag)
                    reg_busy[commit_rd] <= 1'b0;
            end
            // Issue comes last so the new tag wins
            if (issue_valid && issue_rd != '0) begin
                reg_busy[issue_rd] <= 1'b1;
                reg_tag[issue_rd] <= alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/ooo_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            issue_valid,
    input  ooo_pkg::alu_op_e               issue_op,
    input  wire [ooo_pkg::REG_IDX_W-1:0]   issue_rd,
    input  wire [ooo_pkg::REG_IDX_W-1:0]   issue_rs1,
    input  wire [ooo_pkg::REG_IDX_W-1:0]   issue_rs2,
    input  wire [ooo_pkg::IMM_W-1:0]       issue_imm,
    output logic                           issue_credit,
    output logic                           commit_valid,
    output logic [ooo_pkg::REG_IDX_W-1:0]  commit_rd,
    output logic [ooo_pkg::DATA_W-1:0]     commit_data
);

    // Allocation and operand lookup
    logic [ooo_pkg::TAG_W-1:0]  alloc_tag;
    logic [ooo_pkg::TAG_W-1:0]  rob_rd_tag1, rob_rd_tag2;
    logic                       rob_rd_done1, rob_rd_done2;
    logic [ooo_pkg::DATA_W-1:0] rob_rd_data1, rob_rd_data2;
    logic                       src1_ready, src2_ready;
    logic [ooo_pkg::TAG_W-1:0]  src1_tag, src2_tag;
    logic [ooo_pkg::DATA_W-1:0] src1_val, src2_val;

    // Dispatch to the ALU
    logic                       ex_valid;
    ooo_pkg::alu_op_e           ex_op;
    logic [ooo_pkg::DATA_W-1:0] ex_a, ex_b;
    logic [ooo_pkg::TAG_W-1:0]  ex_tag;

    // Common data bus
    logic                       cdb_valid;
    logic [ooo_pkg::TAG_W-1:0]  cdb_tag;
    logic [ooo_pkg::DATA_W-1:0] cdb_data;

    logic [ooo_pkg::TAG_W-1:0]  commit_tag;

    reg_rename u_rename (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue_rd(issue_rd),
        .issue_rs1(issue_rs1), .issue_rs2(issue_rs2),
        .alloc_tag(alloc_tag),
        .rob_rd_done1(rob_rd_done1), .rob_rd_data1(rob_rd_data1),
        .rob_rd_done2(rob_rd_done2), .rob_rd_data2(rob_rd_data2),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .commit_valid(commit_valid), .commit_rd(commit_rd),
        .commit_tag(commit_tag), .commit_data(commit_data),
        .rob_rd_tag1(rob_rd_tag1), .rob_rd_tag2(rob_rd_tag2),
        .src1_ready(src1_ready), .src1_tag(src1_tag), .src1_val(src1_val),
        .src2_ready(src2_ready), .src2_tag(src2_tag), .src2_val(src2_val)
    );

    reorder_buffer u_rob (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue_rd(issue_rd),
        .rob_rd_tag1(rob_rd_tag1), .rob_rd_tag2(rob_rd_tag2),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .alloc_tag(alloc_tag),
        .rob_rd_done1(rob_rd_done1), .rob_rd_data1(rob_rd_data1),
        .rob_rd_done2(rob_rd_done2), .rob_rd_data2(rob_rd_data2),
        .issue_credit(issue_credit),
        .commit_valid(commit_valid), .commit_rd(commit_rd),
        .commit_tag(commit_tag), .commit_data(commit_data)
    );

    reservation_station u_rs (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_imm(issue_imm),
        .alloc_tag(alloc_tag),
        .src1_ready(src1_ready), .src1_tag(src1_tag), .src1_val(src1_val),
        .src2_ready(src2_ready), .src2_tag(src2_tag), .src2_val(src2_val),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_a(ex_a), .ex_b(ex_b), .ex_tag(ex_tag)
    );

    alu_unit u_alu (
        .clk(clk), .rst(rst),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_a(ex_a), .ex_b(ex_b), .ex_tag(ex_tag),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data)
    );

endmodule

`default_nettype wire

// ==== verif/ooo_core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core_checker (
    input wire clk,
    input wire rst,
    input wire issue_valid,
    input wire issue_credit,
    input wire commit_valid,
    input wire cdb_valid
);

    int fail_count = 0;
    int issued;
    int credits;
    int outstanding;

    always_ff @(posedge clk) begin
        if (rst) begin
            issued <= 0;
            credits <= 0;
        end else begin
            if (issue_valid)
                issued <= issued + 1;
            if (issue_credit)
                credits <= credits + 1;
        end
    end

    // Entries held by the sender side of the window
    always_comb outstanding = issued - credits + ooo_pkg::ROB_DEPTH;

    no_commit_after_reset: assert property (@(posedge clk)
        $past(rst) && !rst |-> !commit_valid)
        else begin
            fail_count++;
            $error("commit_valid high in the first cycle after reset");
        end

    credit_window: assert property (@(posedge clk) disable iff (rst)
        credits >= ooo_pkg::ROB_DEPTH |-> outstanding <= ooo_pkg::ROB_DEPTH)
        else begin
            fail_count++;
            $error("More than ROB_DEPTH instructions outstanding: %0d", outstanding);
        end

    no_cdb_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !cdb_valid)
        else begin
            fail_count++;
            $error("cdb_valid high during reset");
        end

    known_outputs: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(issue_credit) && !$isunknown(commit_valid))
        else begin
            fail_count++;
            $error("issue_credit or commit_valid unknown");
        end

endmodule

bind ooo_core ooo_core_checker u_checker (
    .clk(clk),
    .rst(rst),
    .issue_valid(issue_valid),
    .issue_credit(issue_credit),
    .commit_valid(commit_valid),
    .cdb_valid(cdb_valid)
);

`default_nettype wire

// ==== verif/ooo_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb;

    localparam int NUM_TESTS = 6;
    localparam int INSTR_PER_TEST = 24;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * INSTR_PER_TEST * 10 + 200;
    localparam logic [31:0] LFSR_SEED = 32'd78891;
    localparam int EXP_DEPTH = 256;

    logic                           clk;
    logic                           rst;
    logic                           issue_valid;
    ooo_pkg::alu_op_e               issue_op;
    logic [ooo_pkg::REG_IDX_W-1:0]  issue_rd, issue_rs1, issue_rs2;
    logic [ooo_pkg::IMM_W-1:0]      issue_imm;
    logic                           issue_credit;
    logic                           commit_valid;
    logic [ooo_pkg::REG_IDX_W-1:0]  commit_rd;
    logic [ooo_pkg::DATA_W-1:0]     commit_data;

    // Reference registers and the expected commit stream
    logic [31:0] ref_regs [ooo_pkg::NUM_REGS];
    logic [3:0]  exp_rd [EXP_DEPTH];
    logic [31:0] exp_data [EXP_DEPTH];
    logic [7:0]  exp_head, exp_tail;
    logic [3:0]  head_rd;
    logic [31:0] head_data;

    int credits = 0;
    int errors = 0;
    int issued_total = 0;
    logic [31:0] lfsr = LFSR_SEED;

    ooo_core dut (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_rd(issue_rd),
        .issue_rs1(issue_rs1), .issue_rs2(issue_rs2), .issue_imm(issue_imm),
        .issue_credit(issue_credit),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_data(commit_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

    always @(posedge clk) begin
        if (rst)
            exp_head <= '0;
        else if (commit_valid)
            exp_head <= exp_head + 8'd1;
    end

    assign head_rd = exp_rd[exp_head];
    assign head_data = exp_data[exp_head];

    commit_expected: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> exp_head != exp_tail)
        else begin
            errors++;
            $display("Commit arrived with no instruction outstanding");
        end

    commit_rd_check: assert property (@(posedge clk) disable iff (rst)
        commit_valid && exp_head != exp_tail |-> commit_rd == head_rd)
        else begin
            errors++;
            $display("Mismatch commit_rd: got %h expected %h",
                     $sampled(commit_rd), $sampled(head_rd));
        end

    commit_data_check: assert property (@(posedge clk) disable iff (rst)
        commit_valid && exp_head != exp_tail |-> commit_data == head_data)
        else begin
            errors++;
            $display("Mismatch commit_data: got %h expected %h",
                     $sampled(commit_data), $sampled(head_data));
        end

    // Fibonacci LFSR over x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] model_result(input ooo_pkg::alu_op_e op,
            input logic [31:0] a, input logic [31:0] b, input logic [15:0] imm);
        case (op)
            ooo_pkg::OP_ADD:  return a + b;
            ooo_pkg::OP_SUB:  return a - b;
            ooo_pkg::OP_AND:  return a & b;
            ooo_pkg::OP_OR:   return a | b;
            ooo_pkg::OP_XOR:  return a ^ b;
            ooo_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ooo_pkg::OP_ADDI: return a + {{16{imm[15]}}, imm};
            default:          return {imm, 16'h0000};
        endcase
    endfunction

    function automatic int total_errors();
        return errors + dut.u_checker.fail_count;
    endfunction

    // Drop issue and pick up any credit pulse on the falling edge
    task automatic next_cycle();
        @(negedge clk);
        issue_valid = 1'b0;
        if (issue_credit)
            credits++;
    endtask

    task automatic issue_instr(input ooo_pkg::alu_op_e op, input logic [3:0] rd,
            input logic [3:0] rs1, input logic [3:0] rs2, input logic [15:0] imm);
        logic [31:0] result;
        next_cycle();
        while (credits == 0)
            next_cycle();
        result = model_result(op, ref_regs[rs1], ref_regs[rs2], imm);
        issue_valid = 1'b1;
        issue_op = op;
        issue_rd = rd;
        issue_rs1 = rs1;
        issue_rs2 = rs2;
        issue_imm = imm;
        credits--;
        // Register 0 stays zero but its commit still carries the result
        if (rd != 4'd0)
            ref_regs[rd] = result;
        exp_rd[exp_tail] = rd;
        exp_data[exp_tail] = result;
        exp_tail = exp_tail + 8'd1;
        issued_total++;
    endtask

    task automatic drain();
        while (exp_head != exp_tail)
            next_cycle();
        repeat (3) next_cycle();
        assert (credits == ooo_pkg::ROB_DEPTH)
            else begin
                errors++;
                $display("Mismatch credits: got %h expected %h", credits, ooo_pkg::ROB_DEPTH);
            end
    endtask

    task automatic end_test(input int num, input string name, input int err_start);
        drain();
        $display("Test %0d %s finished with %0d errors", num, name, total_errors() - err_start);
    endtask

    initial begin
        int err_start;
        logic [2:0]  r_op;
        logic [3:0]  r_rd, r_rs1, r_rs2;
        logic [15:0] r_imm;

        rst = 1'b1;
        issue_valid = 1'b0;
        issue_op = ooo_pkg::OP_ADD;
        issue_rd = '0;
        issue_rs1 = '0;
        issue_rs2 = '0;
        issue_imm = '0;
        exp_tail = '0;
        for (int i = 0; i < ooo_pkg::NUM_REGS; i++)
            ref_regs[i] = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Initial credit window with nothing issued
        err_start = total_errors();
        for (int i = 0; i < ooo_pkg::ROB_DEPTH + 4; i++) begin
            next_cycle();
            assert (!commit_valid)
                else begin
                    errors++;
                    $display("Commit seen before any instruction was issued");
                end
        end
        end_test(1, "reset_credits", err_start);

        err_start = total_errors();
        issue_instr(ooo_pkg::OP_ADDI, 4'd1, 4'd0, 4'd0, 16'h0011);
        issue_instr(ooo_pkg::OP_ADDI, 4'd2, 4'd0, 4'd0, 16'hfff0);
        issue_instr(ooo_pkg::OP_ADDI, 4'd3, 4'd0, 4'd0, 16'h0f0f);
        issue_instr(ooo_pkg::OP_ADDI, 4'd4, 4'd0, 4'd0, 16'h7abc);
        issue_instr(ooo_pkg::OP_LUI, 4'd5, 4'd0, 4'd0, 16'hdead);
        issue_instr(ooo_pkg::OP_LUI, 4'd6, 4'd0, 4'd0, 16'h8001);
        issue_instr(ooo_pkg::OP_AND, 4'd7, 4'd3, 4'd5, 16'h0000);
        issue_instr(ooo_pkg::OP_OR, 4'd8, 4'd1, 4'd2, 16'h0000);
        issue_instr(ooo_pkg::OP_XOR, 4'd9, 4'd4, 4'd6, 16'h0000);
        issue_instr(ooo_pkg::OP_SLT, 4'd10, 4'd2, 4'd1, 16'h0000);
        issue_instr(ooo_pkg::OP_SUB, 4'd11, 4'd1, 4'd4, 16'h0000);
        end_test(2, "independent_ops", err_start);

        // Each instruction reads the previous result
        err_start = total_errors();
        issue_instr(ooo_pkg::OP_ADDI, 4'd1, 4'd0, 4'd0, 16'd3);
        for (int i = 0; i < 12; i++) begin
            if (i % 2 == 0)
                issue_instr(ooo_pkg::OP_ADDI, 4'd1, 4'd1, 4'd0, 16'(i * 5 + 1));
            else
                issue_instr(ooo_pkg::OP_ADD, 4'd1, 4'd1, 4'd1, 16'h0000);
        end
        end_test(3, "dependency_chain", err_start);

        err_start = total_errors();
        for (int i = 0; i < 20; i++) begin
            if (i % 2 == 0)
                issue_instr(ooo_pkg::OP_SUB, 4'd3, 4'd3, 4'd2, 16'h0000);
            else
                issue_instr(ooo_pkg::OP_ADDI, 4'((i / 2) % 4 + 12), 4'd0, 4'd0, 16'(i * 257));
        end
        end_test(4, "chain_interleaved", err_start);

        // Back to back until the credits run dry
        err_start = total_errors();
        for (int i = 0; i < INSTR_PER_TEST; i++) begin
            r_op = 3'(rand_bits(3));
            r_rd = 4'(rand_bits(4));
            r_rs1 = 4'(rand_bits(4));
            r_rs2 = 4'(rand_bits(4));
            r_imm = 16'(rand_bits(16));
            issue_instr(ooo_pkg::alu_op_e'(r_op), r_rd, r_rs1, r_rs2, r_imm);
        end
        end_test(5, "random_credit_stall", err_start);

        err_start = total_errors();
        issue_instr(ooo_pkg::OP_ADDI, 4'd0, 4'd0, 4'd0, 16'h1234);
        issue_instr(ooo_pkg::OP_ADD, 4'd7, 4'd0, 4'd0, 16'h0000);
        issue_instr(ooo_pkg::OP_ADDI, 4'd8, 4'd0, 4'd0, 16'h0001);
        issue_instr(ooo_pkg::OP_OR, 4'd9, 4'd0, 4'd8, 16'h0000);
        end_test(6, "register_zero", err_start);

        $display("Tests run: %0d, instructions: %0d, errors: %0d",
                 NUM_TESTS, issued_total, total_errors());
        if (total_errors() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
src/ooo_pkg.sv
src/alu_unit.sv
src/reservation_station.sv
src/reorder_buffer.sv
src/reg_rename.sv
src/ooo_core.sv
verif/ooo_core_checker.sv
verif/ooo_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the core and its testbench with Verilator, run, and look for the pass message

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module ooo_core_tb -f all.f; then
    echo "Build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench can report them
out=$(./obj_dir/Vooo_core_tb +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
